// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench
VERILATOR ?= verilator
TOP       ?= tb_memory_subsystem
FILELIST  ?= memory_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

# the log decides pass or fail, not the simulator exit status
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/byte_ram.sv ====
`timescale 1ns/1ps
// byte_ram is a word-wide RAM with per-byte write lanes
// every access waits WAIT_CYCLES edges; busy stays high until it completes
// and the count restarts when the presented request changes
module byte_ram
  import mem_pkg::*;
#(
  parameter int WAIT_CYCLES = 2,   // wait states per access
  parameter int DEPTH_WORDS = 256  // size in words
) (
  input  logic     CLK,
  input  logic     rst,
  input  ram_req_t req,
  output ram_rsp_t rsp
);

  localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;
  localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;

  typedef logic [CNT_W-1:0] cnt_t; // wait-state count
  typedef logic [IDX_W-1:0] idx_t; // word index into the array

  word_t mem [DEPTH_WORDS];

  cnt_t  wait_cnt;   // edges spent on the access in progress
  cnt_t  cnt_now;    // count seen this cycle or zero on a fresh request
  logic  act_valid;  // an access is being counted
  addr_t act_addr;   // address of the counted access
  logic  act_ren;
  logic  act_wen;
  logic  active;     // request present
  logic  restart;    // request is new or differs from the counted one
  logic  done;       // access completes this cycle
  idx_t  word_idx;
  word_t merged;     // stored word with the enabled lanes replaced

  assign active = req.ren | req.wen;

  // a preempted or changed request starts counting again from zero
  assign restart = !act_valid ||
                   (req.addr != act_addr) ||
                   (req.ren != act_ren) ||
                   (req.wen != act_wen);

  assign cnt_now = restart ? '0 : wait_cnt;
  assign done    = active && (cnt_now == cnt_t'(WAIT_CYCLES));

  // word address wraps at the array size
  assign word_idx = idx_t'(req.addr[31:2] % DEPTH_WORDS);

  // byte-lane merge for stores
  always_comb begin
    merged = mem[word_idx];
    for (int b = 0; b < 4; b++) begin
      if (req.byte_en[b]) begin
        merged[8*b +: 8] = req.wdata[8*b +: 8];
      end
    end
  end

  // write commits on the completing edge only
  always_ff @(posedge CLK) begin
    if (done && req.wen) begin
      mem[word_idx] <= merged;
    end
  end

  // wait-state counter
  always_ff @(posedge CLK) begin
    if (rst) begin
      wait_cnt  <= '0;
      act_valid <= 1'b0;
    end else if (!active || done) begin
      wait_cnt  <= '0;   // idle or finished so the next request starts fresh
      act_valid <= 1'b0;
    end else begin
      wait_cnt  <= cnt_now + 1'b1;
      act_valid <= 1'b1;
    end
  end

  // snapshot of the request being counted
  always_ff @(posedge CLK) begin
    if (active) begin
      act_addr <= req.addr;
      act_ren  <= req.ren;
      act_wen  <= req.wen;
    end
  end

  assign rsp.busy  = !done;           // also high while idle
  assign rsp.rdata = mem[word_idx];   // combinational read

  // completion only answers a live request that already waited last cycle
  assert property (@(posedge CLK) disable iff (rst)
    !rsp.busy |-> active && (WAIT_CYCLES == 0 || ($past(active) && $past(rsp.busy))))
    else $error("busy low with no active request that waited out its wait states");

endmodule

// ==== hdl/mem_pkg.sv ====
// mem_pkg holds the types shared by the memory path of the core
// word, address and byte-lane types plus the port request/response structs
package mem_pkg;

  typedef logic [31:0] word_t;    // one data word
  typedef logic [31:0] addr_t;    // byte address
  typedef logic [3:0]  byte_en_t; // bit i enables byte i

  // legal byte-enable codes
  localparam byte_en_t BE_WORD  = 4'hf; // full word
  localparam byte_en_t BE_BYTE0 = 4'h1;
  localparam byte_en_t BE_BYTE1 = 4'h2;
  localparam byte_en_t BE_BYTE2 = 4'h4;
  localparam byte_en_t BE_BYTE3 = 4'h8;
  localparam byte_en_t BE_HALF0 = 4'h3; // low halfword
  localparam byte_en_t BE_HALF1 = 4'hc; // high halfword

  // port request held steady until busy drops
  typedef struct packed {
    logic     ren;
    logic     wen;
    addr_t    addr;
    byte_en_t byte_en;
    word_t    wdata;   // store data in the low bytes as issued by the core
  } ram_req_t;

  // memory back to port
  typedef struct packed {
    logic  busy;   // high until the access completes
    word_t rdata;  // whole addressed word
  } ram_rsp_t;

  // true for the seven byte-enable codes the core may issue
  function automatic logic legal_be(input byte_en_t be);
    case (be)
      BE_WORD, BE_BYTE0, BE_BYTE1, BE_BYTE2,
      BE_BYTE3, BE_HALF0, BE_HALF1: legal_be = 1'b1;
      default:                      legal_be = 1'b0;
    endcase
  endfunction

endpackage

// ==== hdl/memory_controller.sv ====
`timescale 1ns/1ps
// memory_controller arbitrates the fetch and load/store ports onto one RAM
// data port wins whenever it has a request; store data is moved into
// the byte lanes picked by the forwarded byte enable
module memory_controller
  import mem_pkg::*;
(
  input  ram_req_t d_req,   // load/store port
  output ram_rsp_t d_rsp,
  input  ram_req_t i_req,   // fetch port
  output ram_rsp_t i_rsp,
  output ram_req_t mem_req, // toward the RAM
  input  ram_rsp_t mem_rsp
);

  logic     d_active;      // data port owns the RAM this cycle
  byte_en_t sel_be;        // byte enable of the winning port
  word_t    aligned_wdata; // store data shifted into its lanes

  assign d_active = d_req.ren | d_req.wen;
  assign sel_be   = d_active ? d_req.byte_en : i_req.byte_en;

  // lane alignment of the data port store data
  always_comb begin
    case (sel_be)
      BE_WORD, BE_BYTE0, BE_HALF0: aligned_wdata = d_req.wdata;       // already in place
      BE_BYTE1:                    aligned_wdata = d_req.wdata << 8;
      BE_BYTE2, BE_HALF1:          aligned_wdata = d_req.wdata << 16;
      BE_BYTE3:                    aligned_wdata = d_req.wdata << 24;
      default:                     aligned_wdata = d_req.wdata;       // illegal code left as is
    endcase
  end

  // request mux
  always_comb begin
    if (d_active) begin
      mem_req.ren     = d_req.ren;
      mem_req.wen     = d_req.wen;
      mem_req.addr    = d_req.addr;
      mem_req.byte_en = d_req.byte_en;
    end else begin
      mem_req.ren     = i_req.ren;
      mem_req.wen     = i_req.wen;
      mem_req.addr    = i_req.addr;
      mem_req.byte_en = i_req.byte_en;
    end
    mem_req.wdata = aligned_wdata;
  end

  // losing port sees busy
  always_comb begin
    if (d_active) begin
      d_rsp.busy = mem_rsp.busy;
      i_rsp.busy = 1'b1;        // fetch stalls behind data
    end else begin
      d_rsp.busy = 1'b1;        // idle data port reads busy
      i_rsp.busy = mem_rsp.busy;
    end
  end

  // both ports get the full word
  assign d_rsp.rdata = mem_rsp.rdata;
  assign i_rsp.rdata = mem_rsp.rdata;

  // protocol checks on what the core presents
  always_comb begin
    if (mem_req.wen) begin
      // writes reaching the RAM must carry one of the seven codes
      assert final (legal_be(mem_req.byte_en))
        else $error("write with illegal byte enable %h", mem_req.byte_en);
    end
    // a requester raises one operation at a time
    assert final (!(d_req.ren && d_req.wen) && !(i_req.ren && i_req.wen))
      else $error("port raised ren and wen together");
  end

endmodule

// ==== hdl/memory_subsystem.sv ====
`timescale 1ns/1ps
// memory_subsystem has fetch and load/store ports sharing one byte RAM
// the controller adds no latency, so each access takes the RAM's wait states
module memory_subsystem
  import mem_pkg::*;
#(
  parameter int WAIT_CYCLES = 2,   // RAM wait states
  parameter int DEPTH_WORDS = 256  // RAM size in words
) (
  input  logic     CLK,
  input  logic     rst,
  input  ram_req_t i_req,  // fetch port
  output ram_rsp_t i_rsp,
  input  ram_req_t d_req,  // load/store port
  output ram_rsp_t d_rsp
);

  ram_req_t mem_req;  // arbitrated request into the RAM
  ram_rsp_t mem_rsp;  // RAM response fanned out by the controller

  // data-first arbiter with store alignment
  memory_controller u_ctrl (
    .d_req   (d_req),
    .d_rsp   (d_rsp),
    .i_req   (i_req),
    .i_rsp   (i_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  // shared storage
  byte_ram #(
    .WAIT_CYCLES (WAIT_CYCLES),
    .DEPTH_WORDS (DEPTH_WORDS)
  ) u_ram (
    .CLK (CLK),
    .rst (rst),
    .req (mem_req),
    .rsp (mem_rsp)
  );

endmodule

// ==== memory_subsystem.f ====
+incdir+testbench
hdl/mem_pkg.sv
hdl/memory_controller.sv
hdl/byte_ram.sv
hdl/memory_subsystem.sv
testbench/tb_memory_subsystem.sv

// ==== testbench/ram_ref_model.svh ====
// reference model of the shared RAM for the memory subsystem testbench
// expected contents with byte-lane stores plus the arbiter's choice
`ifndef RAM_REF_MODEL_SVH
`define RAM_REF_MODEL_SVH

word_t model_mem [DEPTH_WORDS];  // expected contents with one entry per RAM word

// word slot for a byte address wrapping at the RAM size
function automatic int unsigned word_index(input addr_t addr);
  return (addr >> 2) % DEPTH_WORDS;
endfunction

// initial contents built from the full byte address of the word
function automatic word_t fill_word(input int unsigned idx);
  word_t a;
  a = word_t'(idx) << 2;
  return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
endfunction

// low-byte store data moved into its lanes
function automatic word_t align_store(input word_t data, input byte_en_t be);
  case (be)
    4'h2:       return data << 8;
    4'h4, 4'hc: return data << 16;
    4'h8:       return data << 24;
    default:    return data;        // f, 1 and 3 already sit low
  endcase
endfunction

// 8'hff in every enabled lane
function automatic word_t lane_mask(input byte_en_t be);
  return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
endfunction

function automatic void model_store(input addr_t addr, input byte_en_t be, input word_t data);
  word_t mask;
  int unsigned idx;
  mask = lane_mask(be);
  idx = word_index(addr);
  model_mem[idx] = (model_mem[idx] & ~mask) | (align_store(data, be) & mask);
endfunction

function automatic word_t model_load(input addr_t addr);
  return model_mem[word_index(addr)];
endfunction

// data port owns the RAM whenever it requests anything
function automatic logic data_wins(input ram_req_t d);
  return d.ren | d.wen;
endfunction

`endif

// ==== testbench/tb_memory_subsystem.sv ====
`timescale 1ns/1ps
// testbench for the memory subsystem
// reset, fetch latency, store alignment and data priority checks,
// then random traffic on both ports against a reference model
module tb_memory_subsystem;
  import mem_pkg::*;

  localparam int WAIT_CYCLES = 2;
  localparam int DEPTH_WORDS = 256;
  localparam int N_RANDOM    = 150;  // completed accesses per port
  localparam int N_OPS       = DEPTH_WORDS + 4 + 14 + 2 + 2 * N_RANDOM;
  localparam int CYCLE_LIMIT = N_OPS * (WAIT_CYCLES + 2) * 2 + 100;
  localparam int WAIT_LIMIT  = WAIT_CYCLES + 8;  // edges before one access counts as lost

  logic     CLK;
  logic     rst;
  ram_req_t i_req;
  ram_req_t d_req;
  ram_rsp_t i_rsp;
  ram_rsp_t d_rsp;
  int       errors;
  int       cycles;

  byte_en_t be_codes [7] = '{4'hf, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc};

  `include "ram_ref_model.svh"

  memory_subsystem #(
    .WAIT_CYCLES (WAIT_CYCLES),
    .DEPTH_WORDS (DEPTH_WORDS)
  ) u_dut (
    .CLK   (CLK),
    .rst   (rst),
    .i_req (i_req),
    .i_rsp (i_rsp),
    .d_req (d_req),
    .d_rsp (d_rsp)
  );

  always #50 CLK = ~CLK;  // 100 ns period

  // run limit
  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, accesses still outstanding", cycles);
      $display("errors: %0d", errors);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  function automatic ram_req_t make_req(input logic write, input addr_t addr,
                                        input byte_en_t be, input word_t data);
    ram_req_t r;
    r         = '0;
    r.ren     = !write;
    r.wen     = write;
    r.addr    = addr;
    r.byte_en = be;
    r.wdata   = data;
    return r;
  endfunction

  // 32 hot words with random upper bits to hit the wrap
  function automatic addr_t random_addr();
    return ($urandom & 32'hffff_fc00) | (($urandom % 32) << 2) | ($urandom % 4);
  endfunction

  // loads checked and stores applied to the model once an access completes
  task automatic finish_access(input ram_req_t r, input word_t rd, input string name);
    if (r.wen) begin
      model_store(r.addr, r.byte_en, r.wdata);
    end else begin
      check_value(name, rd, model_load(r.addr));
    end
  endtask

  // one access on one port sampled 1 ns after the falling edge
  task automatic run_access(input logic on_data, input ram_req_t r,
                            output word_t rd, output int edges);
    logic busy;
    @(negedge CLK);
    if (on_data) d_req = r;
    else i_req = r;
    edges = 0;
    #1;
    busy = on_data ? d_rsp.busy : i_rsp.busy;
    while (busy && edges < WAIT_LIMIT) begin
      @(negedge CLK);
      edges++;
      #1;
      busy = on_data ? d_rsp.busy : i_rsp.busy;
    end
    rd = on_data ? d_rsp.rdata : i_rsp.rdata;
    if (busy) report_error("access never completed, busy stayed high");
    else finish_access(r, rd, on_data ? "d_rsp.rdata" : "i_rsp.rdata");
    @(negedge CLK);
    if (on_data) d_req = '0;  // drop after completion
    else i_req = '0;
  endtask

  // fetch and store raised together so the fetch waits for the store
  task automatic priority_phase();
    addr_t addr;
    word_t data;
    int    d_edges;
    int    i_edges;
    addr = random_addr();
    data = $urandom;
    @(negedge CLK);
    d_req   = make_req(1'b1, addr, 4'hf, data);
    i_req   = make_req(1'b0, addr, 4'hf, '0);  // same word so it sees the new data
    d_edges = 0;
    #1;
    while (d_rsp.busy && d_edges < WAIT_LIMIT) begin
      check_value("i_rsp.busy", 32'(i_rsp.busy), 32'd1);
      @(negedge CLK);
      d_edges++;
      #1;
    end
    check_value("i_rsp.busy", 32'(i_rsp.busy), 32'd1);  // held off in the store's last cycle
    check_value("data latency", d_edges, WAIT_CYCLES);
    model_store(addr, 4'hf, data);
    @(negedge CLK);
    d_req   = '0;
    i_edges = 0;
    #1;
    while (i_rsp.busy && i_edges < WAIT_LIMIT) begin
      @(negedge CLK);
      i_edges++;
      #1;
    end
    check_value("fetch latency after data", i_edges, WAIT_CYCLES);
    check_value("i_rsp.rdata", i_rsp.rdata, model_load(addr));
    @(negedge CLK);
    i_req = '0;
  endtask

  // both ports busy at once with only reads on the fetch port
  task automatic random_traffic();
    int   i_done;
    int   d_done;
    int   d_edges;
    int   n;
    logic i_pend;
    logic d_pend;
    i_done  = 0;
    d_done  = 0;
    d_edges = 0;
    i_pend  = 1'b0;
    d_pend  = 1'b0;
    while (i_done < N_RANDOM || d_done < N_RANDOM) begin
      @(negedge CLK);
      if (!i_pend) begin
        i_req = '0;
        if (i_done < N_RANDOM && ($urandom % 4) != 0) begin
          i_req  = make_req(1'b0, random_addr(), 4'hf, '0);
          i_pend = 1'b1;
        end
      end
      if (d_pend) begin
        d_edges++;
      end else begin
        d_req = '0;
        if (d_done < N_RANDOM && ($urandom % 2) == 0) begin
          n       = $urandom_range(6, 0);
          d_req   = make_req(1'(($urandom % 2)), random_addr(), be_codes[n], $urandom);
          d_pend  = 1'b1;
          d_edges = 0;
        end
      end
      #1;
      // losing or idle port must read busy
      if (data_wins(d_req)) check_value("i_rsp.busy", 32'(i_rsp.busy), 32'd1);
      else check_value("d_rsp.busy", 32'(d_rsp.busy), 32'd1);
      if (!i_pend) check_value("i_rsp.busy", 32'(i_rsp.busy), 32'd1);
      if (d_pend && !d_rsp.busy) begin
        check_value("data latency", d_edges, WAIT_CYCLES);  // priority means no restarts
        finish_access(d_req, d_rsp.rdata, "d_rsp.rdata");
        d_pend = 1'b0;
        d_done++;
      end
      if (i_pend && !i_rsp.busy) begin
        finish_access(i_req, i_rsp.rdata, "i_rsp.rdata");
        i_pend = 1'b0;
        i_done++;
      end
    end
    @(negedge CLK);
    i_req = '0;
    d_req = '0;
  endtask

  initial begin
    word_t       rd;
    word_t       old;
    word_t       data;
    word_t       mask;
    addr_t       addr;
    int          edges;
    void'($urandom(73));  // one seed for the run
    CLK      = 1'b0;
    rst      = 1'b1;
    i_req    = '0;
    d_req    = '0;
    errors   = 0;
    cycles   = 0;

    // busy high on both ports through reset with nothing requested
    repeat (8) begin
      #1;
      check_value("i_rsp.busy", 32'(i_rsp.busy), 32'd1);
      check_value("d_rsp.busy", 32'(d_rsp.busy), 32'd1);
      @(negedge CLK);
    end
    rst = 1'b0;
    repeat (2) begin
      #1;
      check_value("i_rsp.busy", 32'(i_rsp.busy), 32'd1);
      check_value("d_rsp.busy", 32'(d_rsp.busy), 32'd1);
      @(negedge CLK);
    end

    // known contents everywhere through the data port
    for (int k = 0; k < DEPTH_WORDS; k++) begin
      run_access(1'b1, make_req(1'b1, addr_t'(k) << 2, 4'hf, fill_word(k)), rd, edges);
    end

    // lone fetches take exactly the wait states
    repeat (4) begin
      run_access(1'b0, make_req(1'b0, random_addr(), 4'hf, '0), rd, edges);
      check_value("fetch latency", edges, WAIT_CYCLES);
    end

    // every byte-enable code followed by a full-word readback
    foreach (be_codes[n]) begin
      addr = random_addr();
      old  = model_load(addr);
      data = $urandom;
      mask = lane_mask(be_codes[n]);
      run_access(1'b1, make_req(1'b1, addr, be_codes[n], data), rd, edges);
      run_access(1'b1, make_req(1'b0, addr, 4'hf, '0), rd, edges);
      check_value("untouched lanes", rd & ~mask, old & ~mask);
      check_value("stored lanes", rd & mask, align_store(data, be_codes[n]) & mask);
    end

    priority_phase();
    random_traffic();

    $display("errors: %0d, cycles: %0d", errors, cycles);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
